//--- src/riscv_defines.svh
`ifndef RISCV_DEFINES_SVH
`define RISCV_DEFINES_SVH

// Top address nibble decode on addr[31:28]
`define ADDR_IO   4'b1000
`define ADDR_BIOS 4'b0100

// Data memory answers to both 0001 and 0011
`define ADDR_DMEM 4'b00?1

// Data memory geometry in 32-bit words
`define DMEM_DEPTH     1024
`define DMEM_ADDR_BITS 10

// Low address bits used to pick an I/O register
`define IO_OFS_BITS 8

// I/O register byte offsets
`define IO_LED_OFS   8'h00
`define IO_STCNT_OFS 8'h04

`endif

//--- src/mem_pkg.sv
package mem_pkg;

    // Major opcode from inst[6:2]
    typedef enum logic [4:0] {
        OPC_LOAD      = 5'b00000,
        OPC_ARI_ITYPE = 5'b00100,
        OPC_AUIPC     = 5'b00101,
        OPC_STORE     = 5'b01000,
        OPC_ARI_RTYPE = 5'b01100,
        OPC_LUI       = 5'b01101,
        OPC_BRANCH    = 5'b11000,
        OPC_JALR      = 5'b11001,
        OPC_JAL       = 5'b11011
    } opcode_e;

    // Load and store widths share the same codes
    typedef enum logic [2:0] {
        FNC_B  = 3'b000,
        FNC_H  = 3'b001,
        FNC_W  = 3'b010,
        FNC_BU = 3'b100,
        FNC_HU = 3'b101
    } funct3_e;

    typedef enum logic [1:0] {
        SIZE_BYTE  = 2'd0,
        SIZE_HALF  = 2'd1,
        SIZE_WORD  = 2'd2,
        SIZE_UNDEF = 2'd3
    } mem_size_e;

    typedef enum logic {
        DIN_RD2   = 1'b0,
        DIN_WDATA = 1'b1
    } din_sel_e;

    typedef enum logic [1:0] {
        SRC_NONE = 2'd0,
        SRC_DMEM = 2'd1,
        SRC_BIOS = 2'd2,
        SRC_IO   = 2'd3
    } load_src_e;

    typedef struct packed {
        din_sel_e  din_sel;
        mem_size_e size;
        logic      br_inst;
        logic      imem_en;
        logic      dmem_en;
        logic      bios_en;
        logic      io_en;
        logic      is_load;
    } mem_ctrl_t;

    typedef struct packed {
        logic [3:0]  wmask;
        logic [31:0] wdata;
        logic [31:0] addr;
    } mem_req_t;

endpackage

//--- src/mem_control.sv
`include "riscv_defines.svh"

module mem_control import mem_pkg::*; (
    input  logic [31:0] pc,
    input  logic [31:0] addr,
    input  logic [31:0] inst,
    input  logic [31:0] wb_inst,
    output mem_ctrl_t   ctrl
);

    opcode_e    opcode;
    opcode_e    wb_opcode;
    logic [2:0] funct3;
    funct3_e    st_fn;
    logic [4:0] rs2;
    logic [4:0] wb_rd;
    logic       wb_has_rd;

    assign opcode    = opcode_e'(inst[6:2]);
    assign wb_opcode = opcode_e'(wb_inst[6:2]);
    assign funct3    = inst[14:12];
    assign st_fn     = funct3_e'(inst[14:12]);
    assign rs2       = inst[24:20];
    assign wb_rd     = wb_inst[11:7];

    // Stores and branches in write-back never update rd
    assign wb_has_rd = (wb_opcode != OPC_STORE) && (wb_opcode != OPC_BRANCH);

    always_comb begin
        ctrl.din_sel = DIN_RD2;
        ctrl.size    = SIZE_UNDEF;
        ctrl.br_inst = 1'b0;
        ctrl.imem_en = 1'b0;
        ctrl.dmem_en = 1'b0;
        ctrl.bios_en = 1'b0;
        ctrl.io_en   = 1'b0;
        ctrl.is_load = 1'b0;

        case (opcode)
            OPC_LOAD: begin
                ctrl.is_load = 1'b1;
                casez (addr[31:28])
                    `ADDR_IO:   ctrl.io_en = 1'b1;
                    `ADDR_BIOS: ctrl.bios_en = 1'b1;
                    `ADDR_DMEM: ctrl.dmem_en = 1'b1;
                    default:    ;
                endcase
            end
            OPC_STORE: begin
                // I/O wins over the imem window selected by pc[30]
                if (addr[31:28] == `ADDR_IO) begin
                    ctrl.io_en = 1'b1;
                end else if (pc[30]) begin
                    ctrl.imem_en = 1'b1;
                end else begin
                    ctrl.dmem_en = 1'b1;
                end

                if (wb_has_rd && (rs2 == wb_rd)) begin
                    ctrl.din_sel = DIN_WDATA;
                end

                case (st_fn)
                    FNC_B:   ctrl.size = SIZE_BYTE;
                    FNC_H:   ctrl.size = SIZE_HALF;
                    FNC_W:   ctrl.size = SIZE_WORD;
                    default: ctrl.size = SIZE_UNDEF;
                endcase
            end
            OPC_BRANCH: begin
                // BEQ BNE BLT BGE BLTU BGEU
                case (funct3)
                    3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111: ctrl.br_inst = 1'b1;
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

endmodule

//--- src/store_align.sv
module store_align import mem_pkg::*; (
    input  mem_ctrl_t   ctrl,
    input  logic [31:0] addr,
    input  logic [31:0] rd2,
    input  logic [31:0] wb_data,
    output mem_req_t    req
);

    logic [31:0] din;

    // Hazard forwarding from write-back
    assign din = (ctrl.din_sel == DIN_WDATA) ? wb_data : rd2;

    assign req.addr = addr;

    always_comb begin
        case (ctrl.size)
            SIZE_BYTE: begin
                req.wdata = {4{din[7:0]}};
                req.wmask = 4'b0001 << addr[1:0];
            end
            SIZE_HALF: begin
                req.wdata = {2{din[15:0]}};
                req.wmask = addr[1] ? 4'b1100 : 4'b0011;
            end
            SIZE_WORD: begin
                req.wdata = din;
                req.wmask = 4'b1111;
            end
            default: begin
                // Not a store so nothing gets written
                req.wdata = din;
                req.wmask = 4'b0000;
            end
        endcase
    end

endmodule

//--- src/data_mem.sv
`include "riscv_defines.svh"

module data_mem import mem_pkg::*; (
    input  logic        clk,
    input  logic        en,
    input  logic        we,
    input  mem_req_t    req,
    output logic [31:0] dout
);

    logic [31:0] mem [`DMEM_DEPTH];
    logic [`DMEM_ADDR_BITS-1:0] idx;

    assign idx = req.addr[`DMEM_ADDR_BITS+1:2];

    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                for (int i = 0; i < 4; i++) begin
                    if (req.wmask[i]) begin
                        mem[idx][8*i +: 8] <= req.wdata[8*i +: 8];
                    end
                end
            end
            // Old contents on a same-cycle write
            dout <= mem[idx];
        end
    end

endmodule

//--- src/io_regs.sv
`include "riscv_defines.svh"

module io_regs import mem_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        en,
    input  logic        we,
    input  mem_req_t    req,
    output logic [31:0] dout,
    output logic [7:0]  led
);

    logic [`IO_OFS_BITS-1:0] ofs;
    logic [31:0]             st_cnt;

    assign ofs = req.addr[`IO_OFS_BITS-1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            led    <= 8'd0;
            st_cnt <= 32'd0;
        end else if (en && we) begin
            // Counts every I/O store at any offset
            st_cnt <= st_cnt + 32'd1;
            if (ofs == `IO_LED_OFS && req.wmask[0]) begin
                led <= req.wdata[7:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            case (ofs)
                `IO_LED_OFS:   dout <= {24'd0, led};
                `IO_STCNT_OFS: dout <= st_cnt;
                default:       dout <= 32'd0;
            endcase
        end
    end

endmodule

//--- src/load_extract.sv
module load_extract import mem_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  mem_ctrl_t   ctrl,
    input  funct3_e     funct3,
    input  logic [31:0] addr,
    input  logic [31:0] dmem_dout,
    input  logic [31:0] bios_dout,
    input  logic [31:0] io_dout,
    output logic [31:0] load_data
);

    load_src_e   src_d;
    load_src_e   src_q;
    funct3_e     funct3_q;
    logic [1:0]  ofs_q;
    logic [31:0] word;
    logic [31:0] shifted;

    always_comb begin
        src_d = SRC_NONE;
        if (ctrl.is_load) begin
            if (ctrl.io_en) begin
                src_d = SRC_IO;
            end else if (ctrl.bios_en) begin
                src_d = SRC_BIOS;
            end else if (ctrl.dmem_en) begin
                src_d = SRC_DMEM;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            src_q <= SRC_NONE;
        end else begin
            src_q <= src_d;
        end
    end

    always_ff @(posedge clk) begin
        funct3_q <= funct3;
        ofs_q    <= addr[1:0];
    end

    always_comb begin
        case (src_q)
            SRC_DMEM: word = dmem_dout;
            SRC_BIOS: word = bios_dout;
            SRC_IO:   word = io_dout;
            default:  word = 32'd0;
        endcase
    end

    // Addressed byte or halfword down to bit 0
    assign shifted = word >> {ofs_q, 3'b000};

    always_comb begin
        case (funct3_q)
            FNC_B:   load_data = {{24{shifted[7]}}, shifted[7:0]};
            FNC_BU:  load_data = {24'd0, shifted[7:0]};
            FNC_H:   load_data = {{16{shifted[15]}}, shifted[15:0]};
            FNC_HU:  load_data = {16'd0, shifted[15:0]};
            default: load_data = word;
        endcase
    end

endmodule

//--- src/mem_stage.sv
module mem_stage import mem_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] pc,
    input  logic [31:0] addr,
    input  logic [31:0] inst,
    input  logic [31:0] wb_inst,
    input  logic [31:0] rd2,
    input  logic [31:0] wb_data,
    input  logic [31:0] bios_dout,
    output logic        br_inst,
    output logic        imem_we,
    output logic [3:0]  imem_wmask,
    output logic [31:0] imem_wdata,
    output logic        bios_en,
    output logic [31:0] load_data,
    output logic [7:0]  led
);

    mem_ctrl_t   ctrl;
    mem_req_t    req;
    logic [31:0] dmem_dout;
    logic [31:0] io_dout;

    mem_control u_mem_control (
        .pc      (pc),
        .addr    (addr),
        .inst    (inst),
        .wb_inst (wb_inst),
        .ctrl    (ctrl)
    );

    store_align u_store_align (
        .ctrl    (ctrl),
        .addr    (addr),
        .rd2     (rd2),
        .wb_data (wb_data),
        .req     (req)
    );

    // Enables are only raised by loads and stores
    data_mem u_data_mem (
        .clk  (clk),
        .en   (ctrl.dmem_en),
        .we   (!ctrl.is_load),
        .req  (req),
        .dout (dmem_dout)
    );

    io_regs u_io_regs (
        .clk   (clk),
        .reset (reset),
        .en    (ctrl.io_en),
        .we    (!ctrl.is_load),
        .req   (req),
        .dout  (io_dout),
        .led   (led)
    );

    load_extract u_load_extract (
        .clk       (clk),
        .reset     (reset),
        .ctrl      (ctrl),
        .funct3    (funct3_e'(inst[14:12])),
        .addr      (addr),
        .dmem_dout (dmem_dout),
        .bios_dout (bios_dout),
        .io_dout   (io_dout),
        .load_data (load_data)
    );

    assign br_inst    = ctrl.br_inst;
    assign imem_we    = ctrl.imem_en;
    assign imem_wmask = req.wmask;
    assign imem_wdata = req.wdata;
    assign bios_en    = ctrl.bios_en;

endmodule

//--- tests/mem_stage_tb.sv
module mem_stage_tb;

    // One trace line with stimulus first and expected outputs after
    typedef struct packed {
        logic [3:0]  test;
        logic [31:0] pc;
        logic [31:0] addr;
        logic [31:0] inst;
        logic [31:0] wb_inst;
        logic [31:0] rd2;
        logic [31:0] wb_data;
        logic [31:0] bios_dout;
        logic        br_inst;
        logic        imem_we;
        logic [3:0]  imem_wmask;
        logic [31:0] imem_wdata;
        logic        bios_en;
        logic [31:0] load_data;
        logic [7:0]  led;
    } trace_t;

    logic        clk;
    logic        reset;
    logic [31:0] pc;
    logic [31:0] addr;
    logic [31:0] inst;
    logic [31:0] wb_inst;
    logic [31:0] rd2;
    logic [31:0] wb_data;
    logic [31:0] bios_dout;
    logic        br_inst;
    logic        imem_we;
    logic [3:0]  imem_wmask;
    logic [31:0] imem_wdata;
    logic        bios_en;
    logic [31:0] load_data;
    logic [7:0]  led;

    trace_t     trace_q[$];
    trace_t     e;
    logic [3:0] cur_test;
    int         cycles = 0;
    int         limit = 0;
    int         errors = 0;
    int         passed = 0;
    int         failed = 0;

    mem_stage dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic read_trace;
        int          fd;
        int          n;
        string       line;
        logic [3:0]  test_f, wmask_f;
        logic [31:0] pc_f, addr_f, inst_f, wbi_f, rd2_f, wbd_f, bios_f, wdata_f, ld_f;
        logic        br_f, we_f, ben_f;
        logic [7:0]  led_f;
        fd = $fopen("tests/mem_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open tests/mem_trace.txt");
        end else begin
            while ($fgets(line, fd) > 0) begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            test_f, pc_f, addr_f, inst_f, wbi_f, rd2_f, wbd_f, bios_f,
                            br_f, we_f, wmask_f, wdata_f, ben_f, ld_f, led_f);
                // Comment lines scan no fields
                if (n == 15) begin
                    trace_q.push_back({test_f, pc_f, addr_f, inst_f, wbi_f, rd2_f, wbd_f,
                                       bios_f, br_f, we_f, wmask_f, wdata_f, ben_f, ld_f,
                                       led_f});
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("FAIL t=%0t %s: got %h expected %h", $time, name, got, exp);
        errors++;
    endtask

    task automatic close_test;
        if (errors == 0) begin
            passed++;
            $display("test %0d: ok", cur_test);
        end else begin
            failed++;
            $display("test %0d: %0d mismatches", cur_test, errors);
        end
        errors = 0;
    endtask

    // Cycle limit armed once the trace length is known
    initial begin
        wait (limit > 0);
        while (cycles <= limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run went past %0d cycles", limit);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        reset     = 1'b1;
        pc        = 32'd0;
        addr      = 32'd0;
        inst      = 32'h0000_0013;
        wb_inst   = 32'h0000_0013;
        rd2       = 32'd0;
        wb_data   = 32'd0;
        bios_dout = 32'd0;
        read_trace();
        if (trace_q.size() == 0) begin
            $display("no usable lines in tests/mem_trace.txt");
            $display("TB FAILED");
            $finish;
        end else begin
            limit = trace_q.size() + 16 + 40;
            cur_test = trace_q[0].test;
            repeat (16) @(posedge clk);
            #1;
            reset = 1'b0;
            foreach (trace_q[i]) begin
                e = trace_q[i];
                if (e.test != cur_test) begin
                    close_test();
                    cur_test = e.test;
                end
                pc        = e.pc;
                addr      = e.addr;
                inst      = e.inst;
                wb_inst   = e.wb_inst;
                rd2       = e.rd2;
                wb_data   = e.wb_data;
                bios_dout = e.bios_dout;
                // Sample just ahead of the next edge
                #2;
                if (br_inst !== e.br_inst) begin
                    report_mismatch("br_inst", 32'(br_inst), 32'(e.br_inst));
                end
                if (imem_we !== e.imem_we) begin
                    report_mismatch("imem_we", 32'(imem_we), 32'(e.imem_we));
                end
                if (e.imem_we && imem_wmask !== e.imem_wmask) begin
                    report_mismatch("imem_wmask", 32'(imem_wmask), 32'(e.imem_wmask));
                end
                if (e.imem_we && imem_wdata !== e.imem_wdata) begin
                    report_mismatch("imem_wdata", imem_wdata, e.imem_wdata);
                end
                if (bios_en !== e.bios_en) begin
                    report_mismatch("bios_en", 32'(bios_en), 32'(e.bios_en));
                end
                if (load_data !== e.load_data) begin
                    report_mismatch("load_data", load_data, e.load_data);
                end
                if (led !== e.led) begin
                    report_mismatch("led", 32'(led), 32'(e.led));
                end
                @(posedge clk);
                #1;
            end
            close_test();
            $display("tests passed: %0d, tests failed: %0d", passed, failed);
            if (failed == 0) begin
                $display("TB PASSED");
            end else begin
                $display("TB FAILED");
            end
            $finish;
        end
    end

endmodule

//--- tests/mem_trace.txt
// test pc addr inst wb_inst rd2 wb_data bios_dout, then expected br_inst imem_we
// imem_wmask imem_wdata bios_en load_data led (load_data answers the line above)
1 00000000 10000000 00502023 00000013 11223344 00000000 00000000 0 0 0 00000000 0 00000000 00
1 00000000 10000002 00501023 00000013 0000aabb 00000000 00000000 0 0 0 00000000 0 00000000 00
1 00000000 10000001 00500023 00000013 000000f0 00000000 00000000 0 0 0 00000000 0 00000000 00
1 00000000 10000000 00002003 00000013 00000000 00000000 00000000 0 0 0 00000000 0 00000000 00
1 00000000 10000002 00001003 00000013 00000000 00000000 00000000 0 0 0 00000000 0 aabbf044 00
1 00000000 10000002 00005003 00000013 00000000 00000000 00000000 0 0 0 00000000 0 ffffaabb 00
1 00000000 10000001 00000003 00000013 00000000 00000000 00000000 0 0 0 00000000 0 0000aabb 00
1 00000000 10000001 00004003 00000013 00000000 00000000 00000000 0 0 0 00000000 0 fffffff0 00
1 00000000 00000000 00000013 00000013 00000000 00000000 00000000 0 0 0 00000000 0 000000f0 00
2 00000000 10000010 00502023 00000293 11111111 22222222 00000000 0 0 0 00000000 0 00000000 00
2 00000000 10000010 00002003 00000013 00000000 00000000 00000000 0 0 0 00000000 0 00000000 00
2 00000000 10000014 00502023 000002a3 33333333 44444444 00000000 0 0 0 00000000 0 22222222 00
2 00000000 10000018 00502023 000002e3 55555555 66666666 00000000 0 0 0 00000000 0 00000000 00
2 00000000 10000014 00002003 00000013 00000000 00000000 00000000 0 0 0 00000000 0 00000000 00
2 00000000 10000018 00002003 00000013 00000000 00000000 00000000 0 0 0 00000000 0 33333333 00
2 00000000 00000000 00000013 00000013 00000000 00000000 00000000 0 0 0 00000000 0 55555555 00
3 40000000 10000022 00501023 00000013 0000beef 00000000 00000000 0 1 c beefbeef 0 00000000 00
3 40000000 00000003 00500023 00000013 000000a5 00000000 00000000 0 1 8 a5a5a5a5 0 00000000 00
3 00000000 40000002 00001003 00000013 00000000 00000000 00000000 0 0 0 00000000 1 00000000 00
3 00000000 40000003 00004003 00000013 00000000 00000000 84211234 0 0 0 00000000 1 ffff8421 00
3 00000000 10000008 00502023 00000013 0badf00d 00000000 c3000000 0 0 0 00000000 0 000000c3 00
3 00000000 30000008 00002003 00000013 00000000 00000000 00000000 0 0 0 00000000 0 00000000 00
3 00000000 00000000 00000013 00000013 00000000 00000000 00000000 0 0 0 00000000 0 0badf00d 00
4 00000000 80000000 00500023 00000013 0000005a 00000000 00000000 0 0 0 00000000 0 00000000 00
4 00000000 80000001 00500023 00000013 00000077 00000000 00000000 0 0 0 00000000 0 00000000 5a
4 00000000 80000000 00502023 00000013 123456c3 00000000 00000000 0 0 0 00000000 0 00000000 5a
4 00000000 80000004 00002003 00000013 00000000 00000000 00000000 0 0 0 00000000 0 00000000 c3
4 00000000 80000000 00004003 00000013 00000000 00000000 00000000 0 0 0 00000000 0 00000003 c3
4 00000000 00000000 00000013 00000013 00000000 00000000 00000000 0 0 0 00000000 0 000000c3 c3
5 00000000 00000000 00000063 00000013 00000000 00000000 00000000 1 0 0 00000000 0 00000000 c3
5 00000000 00000000 00001063 00000013 00000000 00000000 00000000 1 0 0 00000000 0 00000000 c3
5 00000000 00000000 00004063 00000013 00000000 00000000 00000000 1 0 0 00000000 0 00000000 c3
5 00000000 00000000 00005063 00000013 00000000 00000000 00000000 1 0 0 00000000 0 00000000 c3
5 00000000 00000000 00006063 00000013 00000000 00000000 00000000 1 0 0 00000000 0 00000000 c3
5 00000000 00000000 00007063 00000013 00000000 00000000 00000000 1 0 0 00000000 0 00000000 c3
5 00000000 00000000 0000006f 00000013 00000000 00000000 00000000 0 0 0 00000000 0 00000000 c3
5 00000000 00000000 00000037 00000013 00000000 00000000 00000000 0 0 0 00000000 0 00000000 c3
6 00000000 10000040 00502023 00000013 cafe0001 00000000 00000000 0 0 0 00000000 0 00000000 c3
6 00000000 10000040 00002003 00000013 00000000 00000000 00000000 0 0 0 00000000 0 00000000 c3
6 00000000 10000040 00501023 00000013 00005678 00000000 00000000 0 0 0 00000000 0 cafe0001 c3
6 00000000 10000042 00005003 00000013 00000000 00000000 00000000 0 0 0 00000000 0 00000000 c3
6 00000000 10000043 00500023 00000013 0000007e 00000000 00000000 0 0 0 00000000 0 0000cafe c3
6 00000000 10000040 00002003 00000013 00000000 00000000 00000000 0 0 0 00000000 0 00000000 c3
6 00000000 00000000 00000013 00000013 00000000 00000000 00000000 0 0 0 00000000 0 7efe5678 c3

//--- sources.f
+incdir+src
src/mem_pkg.sv
src/mem_control.sv
src/store_align.sv
src/data_mem.sv
src/io_regs.sv
src/load_extract.sv
src/mem_stage.sv
tests/mem_stage_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f sources.f --top-module mem_stage_tb -o mem_stage_tb
output=$(./obj_dir/mem_stage_tb)
echo "$output"
echo "$output" | grep -qx "TB PASSED"
